/* src.f */
usb_rx_pkg.sv
usb_rx_line.sv
usb_rx_timer.sv
usb_rx_shift.sv
usb_rx_rcu.sv
usb_rx_fifo.sv
usb_rx.sv
tb_usb_rx.sv

/* tb_usb_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_usb_rx;

    // bit times: ack, nak, out, in, data, bad sync, bad pid, ack, short data, overflow
    localparam int planned_bits   = 19 + 19 + 35 + 35 + 67 + 11 + 19 + 19 + 30 + 155;
    // plus reset and fifo reads
    localparam int planned_cycles = planned_bits * usb_rx_pkg::clks_per_bit + 32;
    localparam int timeout_cycles = planned_cycles * 3 / 2;
    localparam int done_wait      = 4 * usb_rx_pkg::clks_per_bit;

    logic                   clk;
    logic                   n_rst;
    logic                   d_plus;
    logic                   d_minus;
    logic                   fifo_read;
    usb_rx_pkg::rx_status_t status;
    logic                   store_rx_packet;
    logic [7:0]             fifo_rdata;
    logic                   fifo_empty;
    logic                   fifo_full;

    integer     seed;
    int         cycle_count;
    int         store_count;
    logic       line_level;
    logic [7:0] data_q [$];

    usb_rx uut (
        .clk             (clk),
        .n_rst           (n_rst),
        .d_plus          (d_plus),
        .d_minus         (d_minus),
        .fifo_read       (fifo_read),
        .status          (status),
        .store_rx_packet (store_rx_packet),
        .fifo_rdata      (fifo_rdata),
        .fifo_empty      (fifo_empty),
        .fifo_full       (fifo_full)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            stop_with_error("timeout, the DUT hung before all tests finished");
        end
    end

    // store_rx_packet is a one-cycle pulse
    always @(negedge clk) begin
        if (store_rx_packet === 1'b1) begin
            store_count = store_count + 1;
        end
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_packet(input usb_rx_pkg::rx_packet_t exp);
        usb_rx_pkg::rx_packet_t got;
        got = status.packet;
        if (got !== exp) begin
            stop_with_error($sformatf("** Error status.packet: expected %h (%s), got %h (%s)",
                exp, exp.name(), got, got.name()));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            stop_with_error($sformatf("** Error %s: expected %h, got %h", name, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            stop_with_error($sformatf("** Error %s: expected %h, got %h", name, exp, got));
        end
    endtask

    task automatic hold_bit_times(input int bits);
        repeat (bits * usb_rx_pkg::clks_per_bit) @(posedge clk);
        #10;
    endtask

    // msb first, nrzi: a zero toggles the line, a one holds it
    task automatic send_bits(input logic [7:0] bits, input int count);
        for (int i = 7; i > 7 - count; i--) begin
            if (!bits[i]) begin
                line_level = ~line_level;
            end
            d_plus  = line_level;
            d_minus = ~line_level;
            hold_bit_times(1);
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        send_bits(value, 8);
    endtask

    // two bit times of se0, then back to idle J
    task automatic send_eop();
        d_plus  = 1'b0;
        d_minus = 1'b0;
        hold_bit_times(2);
        line_level = 1'b1;
        d_plus     = 1'b1;
        d_minus    = 1'b0;
        hold_bit_times(1);
    endtask

    function automatic logic [7:0] pid_byte(input logic [3:0] pid);
        return {~pid, pid};
    endfunction

    function automatic logic [7:0] random_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic wait_done();
        int n;
        n = 0;
        while (!(status.packet_done || status.r_error)) begin
            if (n == done_wait) begin
                stop_with_error("neither packet_done nor r_error rose after the packet");
            end
            @(posedge clk);
            #10;
            n++;
        end
    endtask

    task automatic expect_done(input usb_rx_pkg::rx_packet_t exp);
        wait_done();
        check_flag("status.r_error", 1'b0, status.r_error);
        check_flag("status.packet_done", 1'b1, status.packet_done);
        check_packet(exp);
    endtask

    task automatic expect_error();
        wait_done();
        check_flag("status.r_error", 1'b1, status.r_error);
        check_flag("status.packet_done", 1'b0, status.packet_done);
    endtask

    task automatic drain_fifo();
        logic [7:0] exp;
        while (data_q.size() > 0) begin
            exp = data_q.pop_front();
            check_flag("fifo_empty", 1'b0, fifo_empty);
            check_byte("fifo_rdata", exp, fifo_rdata);
            fifo_read = 1'b1;
            @(posedge clk);
            #10;
            fifo_read = 1'b0;
        end
        check_flag("fifo_empty", 1'b1, fifo_empty);
    endtask

    task automatic test_reset();
        check_flag("status.receiving", 1'b0, status.receiving);
        check_flag("status.r_error", 1'b0, status.r_error);
        check_flag("status.packet_done", 1'b0, status.packet_done);
        check_flag("store_rx_packet", 1'b0, store_rx_packet);
        check_packet(usb_rx_pkg::pkt_none);
        check_flag("fifo_empty", 1'b1, fifo_empty);
        check_flag("fifo_full", 1'b0, fifo_full);
    endtask

    task automatic test_handshake(input logic [3:0] pid, input usb_rx_pkg::rx_packet_t exp);
        send_byte(usb_rx_pkg::sync_byte);
        send_byte(pid_byte(pid));
        send_eop();
        expect_done(exp);
    endtask

    // first byte holds endp bit 0 over the address, second byte endp bits 3..1
    task automatic test_token(input logic [3:0] pid, input logic [6:0] addr,
                              input usb_rx_pkg::rx_packet_t exp);
        send_byte(usb_rx_pkg::sync_byte);
        send_byte(pid_byte(pid));
        send_byte({usb_rx_pkg::dev_endp[0], addr});
        send_byte({5'b10100, usb_rx_pkg::dev_endp[3:1]});
        send_eop();
        expect_done(exp);
    endtask

    task automatic test_data();
        logic [7:0] b;
        store_count = 0;
        send_byte(usb_rx_pkg::sync_byte);
        send_byte(pid_byte(usb_rx_pkg::pid_data0));
        repeat (6) begin
            b = random_byte();
            data_q.push_back(b);
            send_byte(b);
        end
        send_eop();
        expect_done(usb_rx_pkg::pkt_data);
        if (store_count != 1) begin
            stop_with_error($sformatf("store_rx_packet pulsed %0d times for one data packet",
                store_count));
        end
        drain_fifo();
    endtask

    task automatic test_bad_packets();
        send_byte(usb_rx_pkg::sync_byte ^ 8'h02);
        send_eop();
        expect_error();
        send_byte(usb_rx_pkg::sync_byte);
        send_byte(pid_byte(4'h0));
        send_eop();
        expect_error();
        check_packet(usb_rx_pkg::pkt_error);
        // receiver recovers on the next packet
        test_handshake(usb_rx_pkg::pid_ack, usb_rx_pkg::pkt_ack);
    endtask

    task automatic test_short_data();
        logic [7:0] b;
        store_count = 0;
        b = random_byte();
        data_q.push_back(b);
        send_byte(usb_rx_pkg::sync_byte);
        send_byte(pid_byte(usb_rx_pkg::pid_data1));
        send_byte(b);
        send_bits(random_byte(), 3);
        send_eop();
        expect_error();
        if (store_count != 1) begin
            stop_with_error($sformatf("store_rx_packet pulsed %0d times for one data packet",
                store_count));
        end
        drain_fifo();
    endtask

    // one byte more than the buffer holds
    task automatic test_overflow();
        logic [7:0] b;
        send_byte(usb_rx_pkg::sync_byte);
        send_byte(pid_byte(usb_rx_pkg::pid_data1));
        repeat (usb_rx_pkg::fifo_depth + 1) begin
            b = random_byte();
            data_q.push_back(b);
            send_byte(b);
        end
        send_eop();
        expect_done(usb_rx_pkg::pkt_data);
        check_flag("fifo_full", 1'b1, fifo_full);
        // the byte that found the buffer full is lost
        b = data_q.pop_back();
        drain_fifo();
        check_flag("fifo_full", 1'b0, fifo_full);
    endtask

    initial begin
        seed        = 32'h8847_7540;
        cycle_count = 0;
        store_count = 0;
        line_level  = 1'b1;
        n_rst       = 1'b0;
        d_plus      = 1'b1;
        d_minus     = 1'b0;
        fifo_read   = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        n_rst = 1'b1;
        test_reset();
        test_handshake(usb_rx_pkg::pid_ack, usb_rx_pkg::pkt_ack);
        test_handshake(usb_rx_pkg::pid_nak, usb_rx_pkg::pkt_nak);
        test_token(usb_rx_pkg::pid_out, usb_rx_pkg::dev_addr, usb_rx_pkg::pkt_out);
        test_token(usb_rx_pkg::pid_in, usb_rx_pkg::dev_addr ^ 7'h0F, usb_rx_pkg::pkt_none);
        test_data();
        test_bad_packets();
        test_short_data();
        test_overflow();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* usb_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx (
    input  wire                    clk,
    input  wire                    n_rst,
    input  wire                    d_plus,
    input  wire                    d_minus,
    input  wire                    fifo_read,
    output usb_rx_pkg::rx_status_t status,
    output logic                   store_rx_packet,
    output logic [7:0]             fifo_rdata,
    output logic                   fifo_empty,
    output logic                   fifo_full
);

    usb_rx_pkg::rx_line_t line;
    logic       shift_enable;
    logic       one_byte;
    logic       timer_clear;
    logic       w_enable_buffer;
    logic [7:0] rcv_data;

    usb_rx_line u_line (
        .clk          (clk),
        .n_rst        (n_rst),
        .d_plus       (d_plus),
        .d_minus      (d_minus),
        .shift_enable (shift_enable),
        .receiving    (status.receiving),
        .line         (line)
    );

    usb_rx_timer u_timer (
        .clk          (clk),
        .n_rst        (n_rst),
        .line         (line),
        .timer_clear  (timer_clear),
        .shift_enable (shift_enable),
        .one_byte     (one_byte)
    );

    usb_rx_shift u_shift (
        .clk          (clk),
        .n_rst        (n_rst),
        .line         (line),
        .shift_enable (shift_enable),
        .rcv_data     (rcv_data)
    );

    usb_rx_rcu u_rcu (
        .clk             (clk),
        .n_rst           (n_rst),
        .line            (line),
        .one_byte        (one_byte),
        .rcv_data        (rcv_data),
        .status          (status),
        .w_enable_buffer (w_enable_buffer),
        .store_rx_packet (store_rx_packet),
        .timer_clear     (timer_clear)
    );

    usb_rx_fifo u_fifo (
        .clk             (clk),
        .n_rst           (n_rst),
        .w_enable_buffer (w_enable_buffer),
        .wdata           (rcv_data),
        .fifo_read       (fifo_read),
        .rdata           (fifo_rdata),
        .empty           (fifo_empty),
        .full            (fifo_full)
    );

endmodule

`default_nettype wire

/* usb_rx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx_fifo (
    input  wire        clk,
    input  wire        n_rst,
    input  wire        w_enable_buffer,
    input  wire  [7:0] wdata,
    input  wire        fifo_read,
    output logic [7:0] rdata,
    output logic       empty,
    output logic       full
);

    logic [7:0] mem [usb_rx_pkg::fifo_depth];
    // top bit is the wrap flag
    logic [usb_rx_pkg::fifo_ptr_w:0] wr_ptr;
    logic [usb_rx_pkg::fifo_ptr_w:0] rd_ptr;
    logic do_write;
    logic do_read;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[usb_rx_pkg::fifo_ptr_w-1:0] == rd_ptr[usb_rx_pkg::fifo_ptr_w-1:0])
                && (wr_ptr[usb_rx_pkg::fifo_ptr_w] != rd_ptr[usb_rx_pkg::fifo_ptr_w]);

    // line cannot stall, so a byte into a full buffer is lost
    assign do_write = w_enable_buffer && !full;
    assign do_read  = fifo_read && !empty;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[usb_rx_pkg::fifo_ptr_w-1:0]] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr[usb_rx_pkg::fifo_ptr_w-1:0]];

    assert property (@(posedge clk) disable iff (!n_rst) fifo_read |-> !empty)
        else $error("fifo_read while the buffer is empty");

endmodule

`default_nettype wire

/* usb_rx_line.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx_line (
    input  wire                  clk,
    input  wire                  n_rst,
    input  wire                  d_plus,
    input  wire                  d_minus,
    input  wire                  shift_enable,
    input  wire                  receiving,
    output usb_rx_pkg::rx_line_t line
);

    logic dp_meta;
    logic dm_meta;
    logic dp_sync;
    logic dm_sync;
    logic dp_last;
    logic dm_last;
    logic level_at_strobe;
    logic was_j;
    logic is_k;

    // two-flop synchronizer, plus one stage of history for the edge
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            dp_meta <= 1'b1;
            dm_meta <= 1'b0;
            dp_sync <= 1'b1;
            dm_sync <= 1'b0;
            dp_last <= 1'b1;
            dm_last <= 1'b0;
        end else begin
            dp_meta <= d_plus;
            dm_meta <= d_minus;
            dp_sync <= dp_meta;
            dm_sync <= dm_meta;
            dp_last <= dp_sync;
            dm_last <= dm_sync;
        end
    end

    // level seen at the previous bit strobe, idle line is J
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            level_at_strobe <= 1'b1;
        end else if (line.edge_start) begin
            level_at_strobe <= 1'b1;
        end else if (shift_enable) begin
            level_at_strobe <= dp_sync;
        end
    end

    assign was_j = dp_last && !dm_last;
    assign is_k  = !dp_sync && dm_sync;

    assign line.edge_start = was_j && is_k && !receiving;
    assign line.eop        = !dp_sync && !dm_sync;
    // nrzi: no change means a one
    assign line.bit_val    = (dp_sync == level_at_strobe);

endmodule

`default_nettype wire

/* usb_rx_pkg.sv */
`default_nettype none

package usb_rx_pkg;

    typedef enum logic [3:0] {
        idle,
        load_sync,
        load_pid,
        token,
        token_endp,
        data_state,
        wait_eop,
        error_state,
        transfer_done
    } rcu_state_t;

    typedef enum logic [2:0] {
        pkt_none,
        pkt_in,
        pkt_out,
        pkt_data,
        pkt_ack,
        pkt_nak,
        pkt_error
    } rx_packet_t;

    // decoded line, one bit lane
    typedef struct packed {
        logic edge_start;
        logic eop;
        logic bit_val;
    } rx_line_t;

    typedef struct packed {
        rx_packet_t packet;
        logic       receiving;
        logic       r_error;
        logic       packet_done;
    } rx_status_t;

    localparam logic [7:0] sync_byte = 8'h01;
    localparam logic [6:0] dev_addr  = 7'h70;
    localparam logic [3:0] dev_endp  = 4'h4;

    // low nibble of the pid byte
    localparam logic [3:0] pid_out   = 4'h1;
    localparam logic [3:0] pid_in    = 4'h9;
    localparam logic [3:0] pid_data0 = 4'h3;
    localparam logic [3:0] pid_data1 = 4'hB;
    localparam logic [3:0] pid_ack   = 4'h2;
    localparam logic [3:0] pid_nak   = 4'hA;

    localparam int clks_per_bit = 8;
    localparam int fifo_depth   = 16;
    localparam int fifo_ptr_w   = 4;

endpackage

`default_nettype wire

/* usb_rx_rcu.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx_rcu (
    input  wire                    clk,
    input  wire                    n_rst,
    input  usb_rx_pkg::rx_line_t   line,
    input  wire                    one_byte,
    input  wire  [7:0]             rcv_data,
    output usb_rx_pkg::rx_status_t status,
    output logic                   w_enable_buffer,
    output logic                   store_rx_packet,
    output logic                   timer_clear
);

    usb_rx_pkg::rcu_state_t state;
    usb_rx_pkg::rcu_state_t next_state;
    usb_rx_pkg::rx_packet_t packet;
    usb_rx_pkg::rx_packet_t next_packet;
    logic endp_lsb;
    logic next_endp_lsb;
    logic first_write;
    logic next_first_write;
    logic one_byte_d;
    logic byte_done;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state       <= usb_rx_pkg::idle;
            packet      <= usb_rx_pkg::pkt_none;
            endp_lsb    <= 1'b0;
            first_write <= 1'b0;
            one_byte_d  <= 1'b0;
        end else begin
            state       <= next_state;
            packet      <= next_packet;
            endp_lsb    <= next_endp_lsb;
            first_write <= next_first_write;
            one_byte_d  <= one_byte;
        end
    end

    assign byte_done = one_byte && !one_byte_d;

    always_comb begin
        next_state       = state;
        next_packet      = packet;
        next_endp_lsb    = endp_lsb;
        next_first_write = first_write;
        case (state)
            usb_rx_pkg::idle, usb_rx_pkg::error_state, usb_rx_pkg::transfer_done: begin
                if (line.edge_start) begin
                    next_state  = usb_rx_pkg::load_sync;
                    next_packet = usb_rx_pkg::pkt_none;
                end
            end
            usb_rx_pkg::load_sync: begin
                if (line.eop) begin
                    next_state = usb_rx_pkg::error_state;
                end else if (byte_done) begin
                    if (rcv_data == usb_rx_pkg::sync_byte) begin
                        next_state = usb_rx_pkg::load_pid;
                    end else begin
                        next_state = usb_rx_pkg::error_state;
                    end
                end
            end
            usb_rx_pkg::load_pid: begin
                if (line.eop) begin
                    next_state = usb_rx_pkg::error_state;
                end else if (byte_done) begin
                    case (rcv_data[3:0])
                        usb_rx_pkg::pid_out: begin
                            next_state  = usb_rx_pkg::token;
                            next_packet = usb_rx_pkg::pkt_out;
                        end
                        usb_rx_pkg::pid_in: begin
                            next_state  = usb_rx_pkg::token;
                            next_packet = usb_rx_pkg::pkt_in;
                        end
                        usb_rx_pkg::pid_data0, usb_rx_pkg::pid_data1: begin
                            next_state       = usb_rx_pkg::data_state;
                            next_packet      = usb_rx_pkg::pkt_data;
                            next_first_write = 1'b1;
                        end
                        usb_rx_pkg::pid_ack: begin
                            next_state  = usb_rx_pkg::wait_eop;
                            next_packet = usb_rx_pkg::pkt_ack;
                        end
                        usb_rx_pkg::pid_nak: begin
                            next_state  = usb_rx_pkg::wait_eop;
                            next_packet = usb_rx_pkg::pkt_nak;
                        end
                        default: begin
                            next_state  = usb_rx_pkg::error_state;
                            next_packet = usb_rx_pkg::pkt_error;
                        end
                    endcase
                end
            end
            usb_rx_pkg::token: begin
                if (line.eop) begin
                    next_state = usb_rx_pkg::error_state;
                end else if (byte_done) begin
                    if (rcv_data[6:0] == usb_rx_pkg::dev_addr) begin
                        next_endp_lsb = rcv_data[7];
                        next_state    = usb_rx_pkg::token_endp;
                    end else begin
                        // not our address
                        next_packet = usb_rx_pkg::pkt_none;
                        next_state  = usb_rx_pkg::wait_eop;
                    end
                end
            end
            usb_rx_pkg::token_endp: begin
                if (line.eop) begin
                    next_state = usb_rx_pkg::error_state;
                end else if (byte_done) begin
                    if ({rcv_data[2:0], endp_lsb} != usb_rx_pkg::dev_endp) begin
                        next_packet = usb_rx_pkg::pkt_none;
                    end
                    next_state = usb_rx_pkg::wait_eop;
                end
            end
            usb_rx_pkg::data_state: begin
                if (line.eop) begin
                    // byte-aligned end only
                    if (one_byte) begin
                        next_state = usb_rx_pkg::transfer_done;
                    end else begin
                        next_state = usb_rx_pkg::error_state;
                    end
                end else if (byte_done) begin
                    next_first_write = 1'b0;
                end
            end
            usb_rx_pkg::wait_eop: begin
                if (line.eop) begin
                    next_state = usb_rx_pkg::transfer_done;
                end
            end
            default: begin
                next_state = usb_rx_pkg::idle;
            end
        endcase
    end

    assign status.packet      = packet;
    assign status.receiving   = (state == usb_rx_pkg::load_sync)
                              || (state == usb_rx_pkg::load_pid)
                              || (state == usb_rx_pkg::token)
                              || (state == usb_rx_pkg::token_endp)
                              || (state == usb_rx_pkg::data_state)
                              || (state == usb_rx_pkg::wait_eop);
    assign status.r_error     = (state == usb_rx_pkg::error_state);
    assign status.packet_done = (state == usb_rx_pkg::transfer_done);

    assign w_enable_buffer = (state == usb_rx_pkg::data_state) && byte_done && !line.eop;
    assign store_rx_packet = w_enable_buffer && first_write;
    assign timer_clear     = (state == usb_rx_pkg::transfer_done);

    // an error only ends a packet in progress
    assert property (@(posedge clk) disable iff (!n_rst)
        $rose(status.r_error) |-> $past(status.receiving))
        else $error("r_error rose outside a packet, state %s", state.name());

endmodule

`default_nettype wire

/* usb_rx_shift.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx_shift (
    input  wire                  clk,
    input  wire                  n_rst,
    input  usb_rx_pkg::rx_line_t line,
    input  wire                  shift_enable,
    output logic [7:0]           rcv_data
);

    // first bit of the byte walks up to bit 7
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            rcv_data <= '0;
        end else if (shift_enable) begin
            rcv_data <= {rcv_data[6:0], line.bit_val};
        end
    end

endmodule

`default_nettype wire

/* usb_rx_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx_timer (
    input  wire                  clk,
    input  wire                  n_rst,
    input  usb_rx_pkg::rx_line_t line,
    input  wire                  timer_clear,
    output logic                 shift_enable,
    output logic                 one_byte
);

    logic [$clog2(usb_rx_pkg::clks_per_bit)-1:0] count;
    logic [2:0] bit_cnt;
    logic       active;

    // oversample counter, strobe registered one count ahead of mid-bit
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            active       <= 1'b0;
            count        <= '0;
            shift_enable <= 1'b0;
        end else begin
            shift_enable <= 1'b0;
            if (line.edge_start) begin
                active <= 1'b1;
                count  <= '0;
            end else if (timer_clear) begin
                active <= 1'b0;
                count  <= '0;
            end else if (active) begin
                if (count == usb_rx_pkg::clks_per_bit - 1) begin
                    count <= '0;
                end else begin
                    count <= count + 1'b1;
                end
                if (count == (usb_rx_pkg::clks_per_bit / 2) - 2 && !line.eop) begin
                    shift_enable <= 1'b1;
                end
            end
        end
    end

    // bits within the byte
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bit_cnt  <= '0;
            one_byte <= 1'b0;
        end else if (line.edge_start) begin
            bit_cnt  <= '0;
            one_byte <= 1'b0;
        end else if (shift_enable) begin
            bit_cnt  <= bit_cnt + 3'd1;
            one_byte <= (bit_cnt == 3'd7);
        end
    end

    assert property (@(posedge clk) disable iff (!n_rst)
        shift_enable |-> count == (usb_rx_pkg::clks_per_bit / 2) - 1)
        else $error("shift_enable away from mid-bit, count %0d", count);

endmodule

`default_nettype wire
